/* Makefile */
# Verilator build and run for the UDP receive parser

VERILATOR ?= verilator
TOP       ?= udp_rx_tb
FILE_LIST ?= udp_rx.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/udp_rx_frames.svh */
`ifndef UDP_RX_FRAMES_SVH
`define UDP_RX_FRAMES_SVH

////////////////////////////////////////
// Frame under construction
////////////////////////////////////////

logic [7:0] frame_q[$];
logic [7:0] exp_payload_q[$];

// Serial LFSR form of the reflected CRC-32 over the first len bytes
function automatic logic [31:0] crc32_model(input int len);
    logic [31:0] crc;
    logic        feedback;

    crc = 32'hFFFFFFFF;
    for (int n = 0; n < len; n++) begin
        for (int b = 0; b < 8; b++) begin
            feedback = crc[0] ^ frame_q[n][b];
            crc      = crc >> 1;
            if (feedback) begin
                crc = crc ^ 32'hEDB88320;
            end
        end
    end
    return ~crc;
endfunction

// Network order, high byte first
function automatic void push_word(input logic [15:0] word);
    frame_q.push_back(word[15:8]);
    frame_q.push_back(word[7:0]);
endfunction

task automatic build_frame(
    input logic [15:0] ether_type,
    input logic [7:0]  protocol,
    input logic [15:0] ipv4_id,
    input logic [15:0] ipv4_flags,
    input logic [15:0] dst_port,
    input int          payload_len,
    input bit          corrupt_fcs
);
    logic [31:0] rnd;
    logic [31:0] fcs;

    frame_q.delete();
    exp_payload_q.delete();
    // Destination then source MAC
    for (int i = 0; i < MAC_BYTES * 2; i++) begin
        frame_q.push_back(8'(i + 2));
    end
    push_word(ether_type);
    // Version and IHL, DSCP, total length
    frame_q.push_back(8'h45);
    frame_q.push_back(8'h00);
    push_word(16'(IPV4_BYTES + UDP_BYTES + payload_len));
    push_word(ipv4_id);
    push_word(ipv4_flags);
    frame_q.push_back(8'h40);
    frame_q.push_back(protocol);
    // Header checksum unused, then source and destination address
    push_word(16'h0000);
    push_word(16'hc0a8);
    push_word(16'h0001);
    push_word(16'hc0a8);
    push_word(16'h0002);
    // UDP source port, destination port, length, checksum
    push_word(16'd4000);
    push_word(dst_port);
    push_word(16'(UDP_BYTES + payload_len));
    push_word(16'h0000);
    for (int i = 0; i < payload_len; i++) begin
        rnd = next_rand();
        frame_q.push_back(rnd[7:0]);
        exp_payload_q.push_back(rnd[7:0]);
    end
    for (int i = payload_len; i < MIN_PAYLOAD; i++) begin
        frame_q.push_back(8'h00);
    end
    fcs = crc32_model(frame_q.size());
    if (corrupt_fcs) begin
        fcs[15:8] = ~fcs[15:8];
    end
    push_word(fcs[31:16]);
    push_word(fcs[15:0]);
endtask

////////////////////////////////////////
// Byte driver
////////////////////////////////////////

// Up to two idle cycles before each byte when gaps are on
task automatic send_frame(input int nbytes, input bit with_gaps);
    int gap;

    accept_q.delete();
    for (int n = 0; n < nbytes; n++) begin
        gap = (with_gaps && n > 0) ? int'(next_rand() % 32'd3) : 0;
        repeat (gap) begin
            @(posedge clock);
            #1;
            rx_valid     = 1'b0;
            rx_byte.sof  = 1'b0;
            rx_byte.data = 8'hee;
        end
        @(posedge clock);
        #1;
        rx_valid     = 1'b1;
        rx_byte.sof  = (n == 0);
        rx_byte.data = frame_q[n];
        accept_q.push_back(edge_count + 1);
    end
    @(posedge clock);
    #1;
    rx_valid    = 1'b0;
    rx_byte.sof = 1'b0;
endtask

`endif

/* dv/udp_rx_tb.sv */
`timescale 1ns/10ps
`include "udp_rx_cfg.svh"

module udp_rx_tb import udp_rx_pkg::*; ();

localparam int CLOCK_PERIOD      = 10;
localparam int MAC_BYTES         = int'(`UDP_RX_MAC_BYTES);
localparam int IPV4_BYTES        = int'(`UDP_RX_IPV4_HEADER_BYTES);
localparam int UDP_BYTES         = int'(`UDP_RX_UDP_HEADER_BYTES);
localparam int MIN_PAYLOAD       = int'(`UDP_RX_MIN_PAYLOAD);
// Both MACs and the EtherType, then both headers
localparam int PAYLOAD_AT        = MAC_BYTES * 2 + 2 + IPV4_BYTES + UDP_BYTES;
// Sum of all frames below, each byte takes at most three cycles
localparam int TOTAL_FRAME_BYTES = 719;
localparam int WATCHDOG_MARGIN   = 200;

logic        clock;
logic        reset_n;
rx_byte_t    rx_byte;
logic        rx_valid;
data_byte_t  payload_byte;
logic        payload_valid;
logic        frame_good;
logic        frame_bad;
frame_info_t frame_info;

int          edge_count = 0;
logic [31:0] rand_state = 32'd41686;
int          accept_q[$];
logic [7:0]  got_payload_q[$];
int          got_edge_q[$];
int          verdict_q[$];
int          verdict_edge_q[$];

udp_rx_top UUT (
    .clock         (clock),
    .reset_n       (reset_n),
    .rx_byte       (rx_byte),
    .rx_valid      (rx_valid),
    .payload_byte  (payload_byte),
    .payload_valid (payload_valid),
    .frame_good    (frame_good),
    .frame_bad     (frame_bad),
    .frame_info    (frame_info)
);

initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
end

always @(posedge clock) begin
    edge_count <= edge_count + 1;
end

// Outputs sampled mid cycle, tagged with the edge that produced them
always @(negedge clock) begin
    if (payload_valid) begin
        got_payload_q.push_back(payload_byte);
        got_edge_q.push_back(edge_count);
    end
    if (frame_good || frame_bad) begin
        verdict_q.push_back(frame_good ? 1 : 0);
        verdict_edge_q.push_back(edge_count);
    end
end

function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
endfunction

`include "udp_rx_frames.svh"

////////////////////////////////////////
// Checking
////////////////////////////////////////

task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on error");
endtask

task automatic check_value(
    input string       test,
    input string       what,
    input logic [63:0] expected,
    input logic [63:0] actual
);
    if (expected !== actual) begin
        fail_run($sformatf("Fail %s: %s expected 0x%0h, actual 0x%0h",
                           test, what, expected, actual));
    end
endtask

// With none expected, wait long enough to catch a stray pulse
task automatic wait_verdicts(input int count);
    int waited;

    waited = 0;
    while (waited < 4 && (count == 0 || verdict_q.size() < count)) begin
        @(negedge clock);
        #1;
        waited++;
    end
endtask

task automatic check_frame(
    input string test,
    input bit    expect_verdict,
    input bit    expect_good,
    input bit    after_abort
);
    int n_verdicts;

    n_verdicts = int'(expect_verdict) + int'(after_abort);
    wait_verdicts(n_verdicts);
    check_value(test, "payload count", 64'(exp_payload_q.size()), 64'(got_payload_q.size()));
    foreach (exp_payload_q[i]) begin
        check_value(test, "payload byte", 64'(exp_payload_q[i]), 64'(got_payload_q[i]));
        check_value(test, "payload edge", 64'(accept_q[PAYLOAD_AT + i]), 64'(got_edge_q[i]));
    end
    check_value(test, "verdict count", 64'(n_verdicts), 64'(verdict_q.size()));
    // Abort pulse follows the interrupting start byte
    if (after_abort) begin
        check_value(test, "abort verdict", 64'(0), 64'(verdict_q.pop_front()));
        check_value(test, "abort edge", 64'(accept_q[0]), 64'(verdict_edge_q.pop_front()));
    end
    if (expect_verdict) begin
        check_value(test, "verdict good", 64'(expect_good), 64'(verdict_q.pop_front()));
        check_value(test, "verdict edge", 64'(accept_q[accept_q.size() - 1]),
                    64'(verdict_edge_q.pop_front()));
    end
    got_payload_q.delete();
    got_edge_q.delete();
    verdict_q.delete();
    verdict_edge_q.delete();
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

// Known check value of the ASCII digits 1 to 9
task automatic check_crc_model();
    frame_q.delete();
    for (int i = 0; i < 9; i++) begin
        frame_q.push_back(8'(8'h31 + i));
    end
    check_value("crc_model", "check value", 64'(32'hCBF43926), 64'(crc32_model(9)));
endtask

task automatic test_good_frame();
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h1a2b, 16'h4000,
                16'd5001, 40, 1'b0);
    send_frame(frame_q.size(), 1'b0);
    check_frame("test_good_frame", 1'b1, 1'b1, 1'b0);
    check_value("test_good_frame", "frame info", 64'({16'd5001, 16'h1a2b, 16'h4000}),
                64'(frame_info));
endtask

task automatic test_short_padded();
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0201, 16'h0000,
                16'd68, 5, 1'b0);
    send_frame(frame_q.size(), 1'b0);
    check_frame("test_short_padded", 1'b1, 1'b1, 1'b0);
endtask

task automatic test_bad_fcs();
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0202, 16'h0000,
                16'd69, 24, 1'b1);
    send_frame(frame_q.size(), 1'b0);
    check_frame("test_bad_fcs", 1'b1, 1'b0, 1'b0);
endtask

task automatic test_dropped();
    frame_info_t info_before;

    info_before = frame_info;
    build_frame(16'h86dd, `UDP_RX_PROTOCOL_UDP, 16'h0101, 16'h0000, 16'd53, 10, 1'b0);
    send_frame(frame_q.size(), 1'b0);
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, 8'h06, 16'h0102, 16'h0000, 16'd53, 10, 1'b0);
    send_frame(frame_q.size(), 1'b0);
    // Fragment offset of five blocks
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0103, 16'h0005,
                16'd53, 10, 1'b0);
    send_frame(frame_q.size(), 1'b0);
    exp_payload_q.delete();
    check_frame("test_dropped", 1'b0, 1'b0, 1'b0);
    check_value("test_dropped", "held frame info", 64'(info_before), 64'(frame_info));
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0104, 16'h4000,
                16'd53, 12, 1'b0);
    send_frame(frame_q.size(), 1'b0);
    check_frame("test_dropped", 1'b1, 1'b1, 1'b0);
endtask

task automatic test_abort();
    // Cut off after the third UDP header byte
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0401, 16'h0000,
                16'd6000, 20, 1'b0);
    send_frame(PAYLOAD_AT - 5, 1'b0);
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0402, 16'h0000,
                16'd6001, 20, 1'b0);
    send_frame(frame_q.size(), 1'b0);
    check_frame("test_abort", 1'b1, 1'b1, 1'b1);
endtask

task automatic test_gaps();
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0301, 16'h0000,
                16'd7000, 30, 1'b0);
    send_frame(frame_q.size(), 1'b1);
    check_frame("test_gaps", 1'b1, 1'b1, 1'b0);
    build_frame(`UDP_RX_ETHER_TYPE_IPV4, `UDP_RX_PROTOCOL_UDP, 16'h0302, 16'h0000,
                16'd7001, 7, 1'b0);
    send_frame(frame_q.size(), 1'b1);
    check_frame("test_gaps", 1'b1, 1'b1, 1'b0);
endtask

////////////////////////////////////////
// Sequence and watchdog
////////////////////////////////////////

initial begin
    reset_n  = 1'b0;
    rx_valid = 1'b0;
    rx_byte  = '0;
    repeat (2) @(posedge clock);
    #1;
    reset_n = 1'b1;
    check_value("reset", "output strobes", 64'(0), 64'({payload_valid, frame_good, frame_bad}));
    check_value("reset", "frame info", 64'(0), 64'(frame_info));
    check_crc_model();
    test_good_frame();
    test_short_padded();
    test_bad_fcs();
    test_dropped();
    test_abort();
    test_gaps();
    $display("Result: PASSED");
    $finish;
end

initial begin
    #(CLOCK_PERIOD * (TOTAL_FRAME_BYTES * 3 + WATCHDOG_MARGIN));
    fail_run("Timeout: the tests did not finish in the allowed time");
end

endmodule

/* hw/udp_rx_cfg.svh */
`ifndef UDP_RX_CFG_SVH
`define UDP_RX_CFG_SVH

////////////////////////////////////////
// Protocol field values
////////////////////////////////////////

// EtherType word for IPv4
`define UDP_RX_ETHER_TYPE_IPV4      16'h0800

// IPv4 protocol number for UDP
`define UDP_RX_PROTOCOL_UDP         8'h11

////////////////////////////////////////
// Field lengths in bytes
////////////////////////////////////////

`define UDP_RX_MAC_BYTES            16'd6
`define UDP_RX_IPV4_HEADER_BYTES    16'd20
`define UDP_RX_UDP_HEADER_BYTES     16'd8
`define UDP_RX_FCS_BYTES            16'd4

// Shorter UDP payloads are followed by zero pad
`define UDP_RX_MIN_PAYLOAD          16'd18

`endif

/* hw/udp_rx_fcs_check.sv */
`timescale 1ns/10ps

module udp_rx_fcs_check import udp_rx_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  data_byte_t fcs_byte,
    input  logic       fcs_byte_valid,
    input  logic       fcs_start,
    input  logic       fcs_recv_valid,
    input  logic       fcs_end,
    input  logic       frame_abort,
    output logic       frame_good,
    output logic       frame_bad
);

// Reflected form of the IEEE 802.3 polynomial
localparam logic [31:0] CRC_POLY = 32'hEDB88320;
localparam logic [31:0] CRC_SEED = 32'hFFFFFFFF;

logic [31:0] crc_q;
logic [31:0] crc_base;
logic [31:0] crc_next;
logic [23:0] recv_q;
logic [31:0] recv_word;
logic        crc_match;

// One byte of the reflected CRC, LSB first
function automatic logic [31:0] crc32_byte(
    input logic [31:0] crc,
    input data_byte_t  data
);
    logic [31:0] c;

    c = crc ^ {24'd0, data};
    for (int i = 0; i < 8; i++) begin
        if (c[0]) begin
            c = (c >> 1) ^ CRC_POLY;
        end
        else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

////////////////////////////////////////
// Running CRC and received word
////////////////////////////////////////

always_comb begin
    crc_base  = fcs_start ? CRC_SEED : crc_q;
    crc_next  = crc32_byte(crc_base, fcs_byte);
    // Last check byte completes the word
    recv_word = {recv_q, fcs_byte};
    crc_match = (recv_word == ~crc_q);
end

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        crc_q <= CRC_SEED;
    end
    else if (fcs_byte_valid) begin
        crc_q <= crc_next;
    end
end

always_ff @(posedge clock) begin
    if (fcs_recv_valid) begin
        recv_q <= recv_word[23:0];
    end
end

////////////////////////////////////////
// Verdict
////////////////////////////////////////

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        frame_good <= 1'b0;
        frame_bad  <= 1'b0;
    end
    else begin
        frame_good <= fcs_end && crc_match;
        frame_bad  <= frame_abort || (fcs_end && !crc_match);
    end
end

// Relies on the parser never ending and aborting a frame at once
verdict_exclusive: assert property (
    @(posedge clock) disable iff (!reset_n)
    !(frame_good && frame_bad)
);

endmodule

/* hw/udp_rx_header_parser.sv */
`timescale 1ns/10ps
`include "udp_rx_cfg.svh"

module udp_rx_header_parser import udp_rx_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  rx_byte_t    rx_byte,
    input  logic        rx_valid,
    output data_byte_t  payload_byte,
    output logic        payload_valid,
    output frame_info_t frame_info,
    output data_byte_t  fcs_byte,
    output logic        fcs_byte_valid,
    output logic        fcs_start,
    output logic        fcs_recv_valid,
    output logic        fcs_end,
    output logic        frame_abort
);

// Last byte index of each fixed field
localparam logic [15:0] MAC_LAST  = `UDP_RX_MAC_BYTES + `UDP_RX_MAC_BYTES - 16'd1;
localparam logic [15:0] TYPE_LAST = 16'd1;
localparam logic [15:0] IPV4_LAST = `UDP_RX_IPV4_HEADER_BYTES - 16'd1;
localparam logic [15:0] UDP_LAST  = `UDP_RX_UDP_HEADER_BYTES - 16'd1;
localparam logic [15:0] FCS_LAST  = `UDP_RX_FCS_BYTES - 16'd1;

// Byte offsets inside the IPv4 and UDP headers
localparam logic [15:0] IPV4_ID_END    = 16'd5;
localparam logic [15:0] IPV4_FLAGS_END = 16'd7;
localparam logic [15:0] IPV4_PROTO_AT  = 16'd9;
localparam logic [15:0] UDP_DPORT_END  = 16'd3;
localparam logic [15:0] UDP_LEN_END    = 16'd5;

parse_state_t state;
parse_state_t state_next;
logic [15:0]  cnt;
logic [15:0]  cnt_next;
data_byte_t   field_lo;
logic [15:0]  field_word;
logic [15:0]  ipv4_id;
logic [15:0]  ipv4_flags;
data_byte_t   ipv4_protocol;
logic [15:0]  payload_len;
logic [15:0]  pad_len;
logic         need_pad;
logic         fragment;
logic         take;
logic         sof_take;
logic         payload_take;

////////////////////////////////////////
// Byte steering
////////////////////////////////////////

always_comb begin
    take         = rx_valid && !rx_byte.sof;
    sof_take     = rx_valid && rx_byte.sof;
    payload_take = take && (state == ST_PAYLOAD);

    // Two byte fields are big endian
    field_word = {field_lo, rx_byte.data};
    need_pad   = payload_len < `UDP_RX_MIN_PAYLOAD;
    pad_len    = `UDP_RX_MIN_PAYLOAD - payload_len;
    // More fragments bit or a nonzero offset
    fragment   = ipv4_flags[13] || (ipv4_flags[12:0] != 13'd0);

    fcs_byte       = rx_byte.data;
    fcs_start      = sof_take;
    fcs_byte_valid = sof_take ||
                     (take && (state inside {ST_MAC, ST_ETHER_TYPE, ST_IPV4,
                                             ST_UDP, ST_PAYLOAD, ST_PAD}));
    fcs_recv_valid = take && (state == ST_FCS);
    fcs_end        = fcs_recv_valid && (cnt == FCS_LAST);
    // A dropped frame ends quietly
    frame_abort    = sof_take && !(state inside {ST_IDLE, ST_DROP});
end

////////////////////////////////////////
// Field walk
////////////////////////////////////////

always_comb begin
    state_next = state;
    cnt_next   = cnt;

    if (sof_take) begin
        // The start byte is MAC byte 0
        state_next = ST_MAC;
        cnt_next   = 16'd1;
    end
    else if (take) begin
        cnt_next = cnt + 16'd1;
        case (state)
            ST_MAC: begin
                if (cnt == MAC_LAST) begin
                    state_next = ST_ETHER_TYPE;
                    cnt_next   = 16'd0;
                end
            end
            ST_ETHER_TYPE: begin
                if (cnt == TYPE_LAST) begin
                    cnt_next   = 16'd0;
                    state_next = (field_word == `UDP_RX_ETHER_TYPE_IPV4) ? ST_IPV4 : ST_DROP;
                end
            end
            ST_IPV4: begin
                if (cnt == IPV4_LAST) begin
                    cnt_next = 16'd0;
                    if (ipv4_protocol != `UDP_RX_PROTOCOL_UDP || fragment) begin
                        state_next = ST_DROP;
                    end
                    else begin
                        state_next = ST_UDP;
                    end
                end
            end
            ST_UDP: begin
                if (cnt == UDP_LAST) begin
                    cnt_next   = 16'd0;
                    state_next = (payload_len != 16'd0) ? ST_PAYLOAD : ST_PAD;
                end
            end
            ST_PAYLOAD: begin
                if (cnt == payload_len - 16'd1) begin
                    cnt_next   = 16'd0;
                    state_next = need_pad ? ST_PAD : ST_FCS;
                end
            end
            ST_PAD: begin
                if (cnt == pad_len - 16'd1) begin
                    cnt_next   = 16'd0;
                    state_next = ST_FCS;
                end
            end
            ST_FCS: begin
                if (cnt == FCS_LAST) begin
                    cnt_next   = 16'd0;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                // Idle and drop wait for a start byte
                cnt_next = cnt;
            end
        endcase
    end
end

always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
        state         <= ST_IDLE;
        cnt           <= 16'd0;
        payload_valid <= 1'b0;
        frame_info    <= '0;
    end
    else begin
        state         <= state_next;
        cnt           <= cnt_next;
        payload_valid <= payload_take;
        // Only frames that passed the IPv4 checks get here
        if (take && state == ST_UDP && cnt == UDP_DPORT_END) begin
            frame_info.udp_dst_port        <= field_word;
            frame_info.ipv4_identification <= ipv4_id;
            frame_info.ipv4_flags          <= ipv4_flags;
        end
    end
end

////////////////////////////////////////
// Header field capture
////////////////////////////////////////

always_ff @(posedge clock) begin
    if (rx_valid) begin
        field_lo <= rx_byte.data;
    end
    if (payload_take) begin
        payload_byte <= rx_byte.data;
    end
    if (take && state == ST_IPV4) begin
        if (cnt == IPV4_ID_END) begin
            ipv4_id <= field_word;
        end
        if (cnt == IPV4_FLAGS_END) begin
            ipv4_flags <= field_word;
        end
        if (cnt == IPV4_PROTO_AT) begin
            ipv4_protocol <= rx_byte.data;
        end
    end
    if (take && state == ST_UDP && cnt == UDP_LEN_END) begin
        payload_len <= field_word - `UDP_RX_UDP_HEADER_BYTES;
    end
end

////////////////////////////////////////
// Checks
////////////////////////////////////////

// Forwarded bytes stay inside the UDP length
payload_within_length: assert property (
    @(posedge clock) disable iff (!reset_n)
    payload_valid |-> $past(cnt) < $past(payload_len)
);

endmodule

/* hw/udp_rx_pkg.sv */
package udp_rx_pkg;

    ////////////////////////////////////////
    // Byte stream
    ////////////////////////////////////////

    typedef logic [7:0] data_byte_t;

    // One received byte, sof marks the first byte of a frame
    typedef struct packed {
        logic       sof;
        data_byte_t data;
    } rx_byte_t;

    ////////////////////////////////////////
    // Header fields presented per frame
    ////////////////////////////////////////

    typedef struct packed {
        logic [15:0] udp_dst_port;
        logic [15:0] ipv4_identification;
        // Flags in the top three bits, fragment offset below
        logic [15:0] ipv4_flags;
    } frame_info_t;

    ////////////////////////////////////////
    // Parser states
    ////////////////////////////////////////

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_MAC,
        ST_ETHER_TYPE,
        ST_IPV4,
        ST_UDP,
        ST_PAYLOAD,
        ST_PAD,
        ST_FCS,
        ST_DROP
    } parse_state_t;

endpackage

/* hw/udp_rx_top.sv */
`timescale 1ns/10ps

module udp_rx_top import udp_rx_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  rx_byte_t    rx_byte,
    input  logic        rx_valid,
    output data_byte_t  payload_byte,
    output logic        payload_valid,
    output logic        frame_good,
    output logic        frame_bad,
    output frame_info_t frame_info
);

// Parser to CRC check
data_byte_t fcs_byte;
logic       fcs_byte_valid;
logic       fcs_start;
logic       fcs_recv_valid;
logic       fcs_end;
logic       frame_abort;

udp_rx_header_parser u_parser (
    .clock          (clock),
    .reset_n        (reset_n),
    .rx_byte        (rx_byte),
    .rx_valid       (rx_valid),
    .payload_byte   (payload_byte),
    .payload_valid  (payload_valid),
    .frame_info     (frame_info),
    .fcs_byte       (fcs_byte),
    .fcs_byte_valid (fcs_byte_valid),
    .fcs_start      (fcs_start),
    .fcs_recv_valid (fcs_recv_valid),
    .fcs_end        (fcs_end),
    .frame_abort    (frame_abort)
);

udp_rx_fcs_check u_fcs_check (
    .clock          (clock),
    .reset_n        (reset_n),
    .fcs_byte       (fcs_byte),
    .fcs_byte_valid (fcs_byte_valid),
    .fcs_start      (fcs_start),
    .fcs_recv_valid (fcs_recv_valid),
    .fcs_end        (fcs_end),
    .frame_abort    (frame_abort),
    .frame_good     (frame_good),
    .frame_bad      (frame_bad)
);

endmodule

/* udp_rx.f */
+incdir+hw
+incdir+dv
hw/udp_rx_pkg.sv
hw/udp_rx_fcs_check.sv
hw/udp_rx_header_parser.sv
hw/udp_rx_top.sv
dv/udp_rx_tb.sv
